// ==== sources.f ====
design/dma_rd_cfg_pkg.sv
design/dma_rd_seq_pkg.sv
design/dma_rd_sequencer.sv
design/dma_rd_cfg_regs.sv
design/dma_rd_req_gen.sv
design/dma_rd_data_path.sv
design/dma_rd_top.sv
test/dma_rd_l2_model.sv
test/dma_rd_tb.sv

// ==== test/dma_rd_tb.sv ====
`timescale 1ns/1ps

module dma_rd_tb
    import dma_rd_cfg_pkg::*;
();

    localparam int N_TXN      = 5;
    localparam int MAX_SEGS   = 4;
    localparam int MAX_BEATS  = 8;
    localparam int WD_CYCLES  = N_TXN * MAX_SEGS * MAX_BEATS * 25;
    localparam ram_addr_t NOC_BASE_XOR = 13'h1000;

    logic clk;
    logic rst_n;
    logic core_cmd_req, core_cmd_gnt, noc_cmd_req, noc_cmd_gnt;
    ram_addr_t ping_base, pong_base;
    seg_len_t  ping_len, pong_len;
    logic      pp_en;
    pair_num_t pair_num;
    noc_addr_t dst_base;
    logic noc_out_req, noc_out_gnt, cfg_mode;
    noc_addr_t cfg_base_addr;
    seg_len_t  cfg_len;
    logic [DATA_W-1:0] out_data, l2_data;
    logic out_valid, out_last, out_ready, wr_resp, pingpong_rd_done, transaction_done;
    logic [1:0] pingpong_state;
    logic l2_req, l2_gnt, l2_gnt_en, l2_valid, l2_ready;
    ram_addr_t l2_addr;

    // reference model of the running transaction
    int err_cnt, txn_cnt, tests_run, segs, beat_idx, total, pp_wait;
    logic noc_mode, done_seen, gate_open, prev_out_req, resp_pend, pp_armed;
    noc_addr_t exp_dst;
    logic out_ready_nxt, gnt_en_nxt, out_gnt_nxt, resp_nxt;
    logic [1:0] pp_nxt;
    logic [31:0] rng;
    logic beat_fire;

    assign beat_fire = out_valid && out_ready;

    dma_rd_top dma_rd_top_inst (
        .*,
        .core_cfg_ping_base(ping_base), .core_cfg_pong_base(pong_base),
        .core_cfg_ping_len(ping_len), .core_cfg_pong_len(pong_len),
        .core_cfg_pingpong_en(pp_en), .core_cfg_pair_num(pair_num),
        .core_cfg_noc_base_addr(dst_base),
        .noc_cfg_ping_base(ping_base ^ NOC_BASE_XOR),
        .noc_cfg_pong_base(pong_base ^ NOC_BASE_XOR),
        .noc_cfg_ping_len(ping_len), .noc_cfg_pong_len(pong_len),
        .noc_cfg_pingpong_en(pp_en), .noc_cfg_pair_num(pair_num)
    );

    dma_rd_l2_model l2_model_inst (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [DATA_W-1:0] beat_word(input ram_addr_t a);
        return {(DATA_W/16){3'b000, a}};
    endfunction

    task automatic log_error(input string msg);
        err_cnt++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        out_ready      <= out_ready_nxt;
        l2_gnt_en      <= gnt_en_nxt;
        noc_out_gnt    <= out_gnt_nxt;
        wr_resp        <= resp_nxt;
        pingpong_state <= pp_nxt;
    end

    always @(negedge clk) begin : monitor
        logic [31:0] r;
        logic        sel;
        ram_addr_t   base;
        seg_len_t    len;
        logic        fin;
        logic        exp_last;
        r = next_rand();
        assert (!(noc_cmd_gnt && core_cmd_req))
            else log_error("NoC command granted while the core was requesting");

        // a core transaction may end in the cycle that grants the next command
        if (transaction_done) begin
            assert (!noc_mode && !done_seen && segs == total)
                else log_error("unexpected transaction_done pulse");
            if (!noc_mode && !done_seen) begin
                txn_cnt++;
            end
            done_seen = 1'b1;
        end

        if (core_cmd_gnt || noc_cmd_gnt) begin
            noc_mode  = noc_cmd_gnt;
            segs      = 0;
            beat_idx  = 0;
            done_seen = 1'b0;
            gate_open = 1'b1;
            exp_dst   = noc_cmd_gnt ? '0 : dst_base;
            total     = (pair_num == 0) ? 1 : 2 * int'(pair_num);
        end
        sel  = segs[0];
        len  = sel ? pong_len : ping_len;
        base = sel ? pong_base : ping_base;
        if (noc_mode) begin
            base = base ^ NOC_BASE_XOR;
        end
        fin      = (beat_idx == int'(len));
        exp_last = fin && (!noc_mode || (sel ? ((segs >> 1) + 1 == int'(pair_num)) : !pp_en));

        if (noc_out_req) begin
            assert (cfg_base_addr == exp_dst) else log_error("wrong NoC destination address");
            assert (cfg_len == len) else log_error("wrong length on output request");
            assert (cfg_mode == noc_mode) else log_error("wrong mode on output request");
            assert (!(noc_mode && segs > 0 && prev_out_req))
                else log_error("NoC read output request waited for a grant");
        end
        prev_out_req = noc_out_req;

        assert (!l2_req || gate_open) else log_error("L2 read before its ping-pong bit was set");
        if (pingpong_state[segs[0]]) begin
            gate_open = 1'b1;
        end
        // buffer bit for the next segment comes back after a random delay
        if (pp_wait > 0) begin
            pp_wait--;
        end else if (pp_armed) begin
            pp_nxt   = 2'b01 << segs[0];
            pp_armed = 1'b0;
        end

        assert (pingpong_rd_done == (beat_fire && fin && pp_en))
            else log_error("wrong pingpong_rd_done pulse");
        if (beat_fire) begin
            assert (out_data == beat_word(base + ram_addr_t'(beat_idx)))
                else log_error("wrong beat data, beat lost or repeated");
            assert (out_last == exp_last) else log_error("wrong last flag");
            if (fin) begin
                assert (segs < total) else log_error("more segments than configured");
                segs++;
                beat_idx  = 0;
                exp_dst   = exp_dst + noc_addr_t'(len) + 1'b1;
                gate_open = 1'b0;
                resp_pend = !noc_mode;
                pp_nxt    = 2'b00;
                pp_wait   = int'(r[8:6]);
                pp_armed  = 1'b1;
                if (noc_mode && segs == total) begin
                    txn_cnt++;
                end
            end else begin
                beat_idx++;
            end
        end

        out_ready_nxt = (r[1:0] != 2'b00);
        gnt_en_nxt    = r[2] | r[3];
        out_gnt_nxt   = noc_out_req && !noc_out_gnt && r[4] && !(noc_mode && segs > 0);
        resp_nxt      = 1'b0;
        if (resp_pend && r[5]) begin
            resp_nxt  = 1'b1;
            resp_pend = 1'b0;
        end
    end

    // each request is held until granted even when core and NoC ask together
    task automatic issue_cmd(input logic use_core, input logic use_noc);
        logic core_pend;
        logic noc_pend;
        core_pend = use_core;
        noc_pend  = use_noc;
        @(posedge clk);
        core_cmd_req <= use_core;
        noc_cmd_req  <= use_noc;
        while (core_pend || noc_pend) begin
            @(negedge clk);
            if (core_cmd_gnt) begin
                core_pend = 1'b0;
            end
            if (noc_cmd_gnt) begin
                noc_pend = 1'b0;
            end
            @(posedge clk);
            core_cmd_req <= core_pend;
            noc_cmd_req  <= noc_pend;
        end
    endtask

    task automatic run_test(input string name, input logic use_core, input logic use_noc,
                            input pair_num_t pairs, input logic pp);
        int err_start;
        int target;
        err_start = err_cnt;
        target    = txn_cnt + int'(use_core) + int'(use_noc);
        @(posedge clk);
        ping_base <= ram_addr_t'(next_rand());
        pong_base <= ram_addr_t'(next_rand());
        ping_len  <= seg_len_t'(next_rand() % MAX_BEATS);
        pong_len  <= seg_len_t'(next_rand() % MAX_BEATS);
        dst_base  <= noc_addr_t'(next_rand());
        pp_en     <= pp;
        pair_num  <= pairs;
        issue_cmd(use_core, use_noc);
        wait (txn_cnt == target);
        tests_run++;
        if (err_cnt == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress", WD_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        rng = 32'h56396a5f;
        {core_cmd_req, noc_cmd_req, noc_out_gnt, out_ready, wr_resp, l2_gnt_en} = '0;
        {ping_base, pong_base, ping_len, pong_len, pp_en, pair_num, dst_base} = '0;
        pingpong_state = 2'b00;
        {noc_mode, done_seen, gate_open, prev_out_req, resp_pend, pp_armed} = '0;
        {out_ready_nxt, gnt_en_nxt, out_gnt_nxt, resp_nxt} = '0;
        pp_nxt = 2'b00;
        exp_dst = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        run_test("core pair 2", 1'b1, 1'b0, 11'd2, 1'b1);
        run_test("noc pair 2", 1'b0, 1'b1, 11'd2, 1'b1);
        run_test("noc pair 1 no ping-pong", 1'b0, 1'b1, 11'd1, 1'b0);
        run_test("arbitration pair 0", 1'b1, 1'b1, 11'd0, 1'b1);
        $display("tests run: %0d, transactions: %0d, errors: %0d", tests_run, txn_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== test/dma_rd_l2_model.sv ====
`timescale 1ns/1ps

module dma_rd_l2_model import dma_rd_cfg_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                l2_req,
    input  logic                l2_gnt_en,
    output logic                l2_gnt,
    input  ram_addr_t           l2_addr,

    output logic                l2_valid,
    output logic [DATA_W-1:0]   l2_data,
    input  logic                l2_ready
);

    localparam int DEPTH = 16;

    ram_addr_t   fifo [DEPTH];
    logic [3:0]  wr_ptr;
    logic [3:0]  rd_ptr;
    logic [4:0]  count;
    ram_addr_t   addr_d1;
    logic        vld_d1;
    logic        push;
    logic        pop;

    assign l2_gnt   = l2_req & l2_gnt_en;
    assign l2_valid = (count != 5'd0);
    // every 16-bit lane carries the word address
    assign l2_data  = {(DATA_W/16){3'b000, fifo[rd_ptr]}};
    assign push     = vld_d1;
    assign pop      = l2_valid & l2_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_d1 <= '0;
            vld_d1  <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            // one stage of array latency before beats queue in the FIFO
            addr_d1 <= l2_addr;
            vld_d1  <= l2_gnt;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {4'b0, push} - {4'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= addr_d1;
        end
    end

endmodule

// ==== design/dma_rd_top.sv ====
`timescale 1ns/1ps

module dma_rd_top import dma_rd_cfg_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                core_cmd_req,
    output logic                core_cmd_gnt,
    input  ram_addr_t           core_cfg_ping_base,
    input  ram_addr_t           core_cfg_pong_base,
    input  seg_len_t            core_cfg_ping_len,
    input  seg_len_t            core_cfg_pong_len,
    input  logic                core_cfg_pingpong_en,
    input  pair_num_t           core_cfg_pair_num,
    input  noc_addr_t           core_cfg_noc_base_addr,

    input  logic                noc_cmd_req,
    output logic                noc_cmd_gnt,
    input  ram_addr_t           noc_cfg_ping_base,
    input  ram_addr_t           noc_cfg_pong_base,
    input  seg_len_t            noc_cfg_ping_len,
    input  seg_len_t            noc_cfg_pong_len,
    input  logic                noc_cfg_pingpong_en,
    input  pair_num_t           noc_cfg_pair_num,

    output logic                noc_out_req,
    input  logic                noc_out_gnt,
    output noc_addr_t           cfg_base_addr,
    output seg_len_t            cfg_len,
    output logic                cfg_mode,

    output logic [DATA_W-1:0]   out_data,
    output logic                out_valid,
    output logic                out_last,
    input  logic                out_ready,

    input  logic                wr_resp,
    input  logic [1:0]          pingpong_state,
    output logic                pingpong_rd_done,
    output logic                transaction_done,

    output logic                l2_req,
    input  logic                l2_gnt,
    output ram_addr_t           l2_addr,
    input  logic                l2_valid,
    input  logic [DATA_W-1:0]   l2_data,
    output logic                l2_ready
);

    // sequencer control towards the other blocks
    logic       cfg_load;
    logic       cfg_src_noc;
    logic       seg_start;
    logic       seg_sel;
    logic       seg_active;
    logic       last_pair;

    // per-segment handshakes back to the sequencer
    logic       seg_end;
    logic       req_done;

    // latched configuration
    ram_addr_t  seg_base;
    seg_len_t   seg_len;
    logic       pingpong_en;
    pair_num_t  pair_num;

    dma_rd_sequencer u_sequencer (.*);

    dma_rd_cfg_regs u_cfg_regs (.*);

    dma_rd_req_gen u_req_gen (.*);

    dma_rd_data_path u_data_path (.*);

endmodule

// ==== design/dma_rd_data_path.sv ====
`timescale 1ns/1ps

module dma_rd_data_path
    import dma_rd_cfg_pkg::*;
    import dma_rd_seq_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic                seg_active,
    input  logic                seg_sel,
    input  seg_len_t            seg_len,
    input  logic                cfg_mode,
    input  logic                pingpong_en,
    input  logic                last_pair,
    input  logic                l2_valid,
    input  logic [DATA_W-1:0]   l2_data,
    input  logic                out_ready,

    output logic [DATA_W-1:0]   out_data,
    output logic                out_valid,
    output logic                out_last,
    output logic                l2_ready,
    output logic                seg_end,
    output logic                pingpong_rd_done
);

    seg_len_t beat_cnt;
    logic     beat_fire;
    logic     final_beat;
    logic     last_rule;

    // beats pass straight through while a segment is being read
    assign out_data  = l2_data;
    assign out_valid = seg_active & l2_valid;
    assign l2_ready  = seg_active & out_ready;
    assign beat_fire = out_valid & out_ready;

    assign final_beat = (beat_cnt == seg_len);

    // NoC read closes the packet only at the very end of its stream
    always_comb begin
        if (!cfg_mode) begin
            last_rule = 1'b1;
        end else if (seg_sel == SEG_PONG) begin
            last_rule = last_pair;
        end else begin
            last_rule = ~pingpong_en;
        end
    end

    assign out_last         = out_valid & final_beat & last_rule;
    assign seg_end          = beat_fire & final_beat;
    assign pingpong_rd_done = seg_end & pingpong_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            beat_cnt <= final_beat ? '0 : beat_cnt + 1'b1;
        end
    end

endmodule

// ==== design/dma_rd_req_gen.sv ====
`timescale 1ns/1ps

module dma_rd_req_gen import dma_rd_cfg_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        seg_start,
    input  logic        seg_active,
    input  logic        seg_end,
    input  ram_addr_t   seg_base,
    input  seg_len_t    seg_len,
    input  logic        l2_gnt,

    output logic        l2_req,
    output ram_addr_t   l2_addr,
    output logic        req_done
);

    ram_addr_t req_addr;
    seg_len_t  req_cnt;
    logic      req_en;
    logic      req_fire;

    assign l2_req   = seg_active & req_en;
    assign l2_addr  = req_addr;
    assign req_fire = l2_req & l2_gnt;
    assign req_done = req_fire & (req_cnt == seg_len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_addr <= '0;
            req_cnt  <= '0;
            req_en   <= 1'b1;
        end else begin
            if (seg_start) begin
                req_addr <= seg_base;
                req_cnt  <= '0;
            end else if (req_done) begin
                // all requests issued while data may still be in flight
                req_en <= 1'b0;
            end else if (req_fire) begin
                req_addr <= req_addr + 1'b1;
                req_cnt  <= req_cnt + 1'b1;
            end

            // re-arm once the last beat has left
            if (seg_end) begin
                req_en <= 1'b1;
            end
        end
    end

endmodule

// ==== design/dma_rd_cfg_regs.sv ====
`timescale 1ns/1ps

module dma_rd_cfg_regs
    import dma_rd_cfg_pkg::*;
    import dma_rd_seq_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cfg_load,
    input  logic        cfg_src_noc,

    input  ram_addr_t   core_cfg_ping_base,
    input  ram_addr_t   core_cfg_pong_base,
    input  seg_len_t    core_cfg_ping_len,
    input  seg_len_t    core_cfg_pong_len,
    input  logic        core_cfg_pingpong_en,
    input  pair_num_t   core_cfg_pair_num,
    input  noc_addr_t   core_cfg_noc_base_addr,

    input  ram_addr_t   noc_cfg_ping_base,
    input  ram_addr_t   noc_cfg_pong_base,
    input  seg_len_t    noc_cfg_ping_len,
    input  seg_len_t    noc_cfg_pong_len,
    input  logic        noc_cfg_pingpong_en,
    input  pair_num_t   noc_cfg_pair_num,

    input  logic        seg_sel,
    input  logic        req_done,

    output ram_addr_t   seg_base,
    output seg_len_t    seg_len,
    output logic        pingpong_en,
    output pair_num_t   pair_num,
    output noc_addr_t   cfg_base_addr,
    output seg_len_t    cfg_len
);

    ram_addr_t ping_base;
    ram_addr_t pong_base;
    seg_len_t  ping_len;
    seg_len_t  pong_len;

    assign seg_base = (seg_sel == SEG_PONG) ? pong_base : ping_base;
    assign seg_len  = (seg_sel == SEG_PONG) ? pong_len : ping_len;
    assign cfg_len  = seg_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ping_base     <= '0;
            pong_base     <= '0;
            ping_len      <= '0;
            pong_len      <= '0;
            pingpong_en   <= 1'b0;
            pair_num      <= '0;
            cfg_base_addr <= '0;
        end else if (cfg_load) begin
            ping_base     <= cfg_src_noc ? noc_cfg_ping_base : core_cfg_ping_base;
            pong_base     <= cfg_src_noc ? noc_cfg_pong_base : core_cfg_pong_base;
            ping_len      <= cfg_src_noc ? noc_cfg_ping_len : core_cfg_ping_len;
            pong_len      <= cfg_src_noc ? noc_cfg_pong_len : core_cfg_pong_len;
            pingpong_en   <= cfg_src_noc ? noc_cfg_pingpong_en : core_cfg_pingpong_en;
            pair_num      <= cfg_src_noc ? noc_cfg_pair_num : core_cfg_pair_num;
            // a NoC read answers into the requester's window from offset zero
            cfg_base_addr <= cfg_src_noc ? '0 : core_cfg_noc_base_addr;
        end else if (req_done) begin
            // next segment lands right after this one's beats
            cfg_base_addr <= cfg_base_addr + noc_addr_t'(seg_len) + 1'b1;
        end
    end

endmodule

// ==== design/dma_rd_sequencer.sv ====
`timescale 1ns/1ps

module dma_rd_sequencer
    import dma_rd_cfg_pkg::*;
    import dma_rd_seq_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        core_cmd_req,
    input  logic        noc_cmd_req,
    input  logic        noc_out_gnt,
    input  logic        wr_resp,
    input  logic [1:0]  pingpong_state,
    input  logic        seg_end,
    input  pair_num_t   pair_num,

    output logic        core_cmd_gnt,
    output logic        noc_cmd_gnt,
    output logic        noc_out_req,
    output logic        cfg_load,
    output logic        cfg_src_noc,
    output logic        cfg_mode,
    output logic        seg_start,
    output logic        seg_sel,
    output logic        seg_active,
    output logic        transaction_done,
    output logic        last_pair
);

    seq_state_t state;
    seq_state_t state_nxt;
    seg_cnt_t   seg_cnt;
    seg_cnt_t   seg_cnt_nxt;
    seg_cnt_t   seg_cnt_inc;
    logic       first_done;
    logic       first_done_nxt;
    logic       mode_nxt;
    logic       done_set;
    logic       out_gnt_eff;
    logic       buf_ready;
    logic       pairs_done;

    assign seg_cnt_inc = seg_cnt + 1'b1;
    assign seg_sel     = seg_cnt[0] ? SEG_PONG : SEG_PING;
    assign seg_active  = (state == ping_rd) || (state == pong_rd);

    // two segments per pair, so the pair count is the counter without its low bit
    assign pairs_done = (seg_cnt[SEG_CNT_W-1:1] == pair_num);
    // seen from inside the segment still running
    assign last_pair  = (seg_cnt_inc[SEG_CNT_W-1:1] == pair_num);

    assign buf_ready = (seg_sel == SEG_PONG) ? pingpong_state[1] : pingpong_state[0];

    // NoC read keeps the output port once the first segment went out
    assign out_gnt_eff = noc_out_gnt | (cfg_mode & first_done);

    always_comb begin
        state_nxt      = state;
        seg_cnt_nxt    = seg_cnt;
        first_done_nxt = first_done;
        mode_nxt       = cfg_mode;
        done_set       = 1'b0;
        core_cmd_gnt   = 1'b0;
        noc_cmd_gnt    = 1'b0;
        noc_out_req    = 1'b0;
        cfg_load       = 1'b0;
        cfg_src_noc    = 1'b0;
        seg_start      = 1'b0;

        case (state)
            idle: begin
                // core wins when both ask in the same cycle
                if (core_cmd_req) begin
                    core_cmd_gnt = 1'b1;
                    cfg_load     = 1'b1;
                    mode_nxt     = 1'b0;
                    state_nxt    = out_req;
                end else if (noc_cmd_req) begin
                    noc_cmd_gnt = 1'b1;
                    cfg_load    = 1'b1;
                    cfg_src_noc = 1'b1;
                    mode_nxt    = 1'b1;
                    state_nxt   = out_req;
                end
            end
            pingpong_check: begin
                if (pairs_done) begin
                    seg_cnt_nxt    = '0;
                    first_done_nxt = 1'b0;
                    done_set       = ~cfg_mode;
                    state_nxt      = idle;
                end else if (buf_ready) begin
                    state_nxt = out_req;
                end
            end
            out_req: begin
                noc_out_req = 1'b1;
                if (out_gnt_eff) begin
                    seg_start = 1'b1;
                    state_nxt = (seg_sel == SEG_PONG) ? pong_rd : ping_rd;
                end
            end
            ping_rd, pong_rd: begin
                if (seg_end) begin
                    seg_cnt_nxt    = seg_cnt_inc;
                    first_done_nxt = 1'b1;
                    // only a NoC write from the core gets a response
                    state_nxt      = cfg_mode ? pingpong_check : out_resp;
                end
            end
            out_resp: begin
                if (wr_resp) begin
                    state_nxt = pingpong_check;
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= idle;
            seg_cnt          <= '0;
            first_done       <= 1'b0;
            cfg_mode         <= 1'b0;
            transaction_done <= 1'b0;
        end else begin
            state            <= state_nxt;
            seg_cnt          <= seg_cnt_nxt;
            first_done       <= first_done_nxt;
            cfg_mode         <= mode_nxt;
            transaction_done <= done_set;
        end
    end

endmodule

// ==== design/dma_rd_seq_pkg.sv ====
package dma_rd_seq_pkg;

    typedef enum logic [2:0] {
        idle,
        pingpong_check,
        out_req,
        ping_rd,
        pong_rd,
        out_resp
    } seq_state_t;

    // segment selector values follow the low bit of the segment counter
    localparam logic SEG_PING = 1'b0;
    localparam logic SEG_PONG = 1'b1;

endpackage

// ==== design/dma_rd_cfg_pkg.sv ====
package dma_rd_cfg_pkg;

    // L2 data memory side
    localparam int RAM_ADDR_W = 13;
    localparam int SEG_LEN_W  = 13;

    // NoC destination side
    localparam int NOC_ADDR_W = 25;

    // one extra bit so the counter can hold two segments per pair
    localparam int PAIR_NUM_W = 11;
    localparam int SEG_CNT_W  = PAIR_NUM_W + 1;

    localparam int DATA_W = 256;

    // word address into L2
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    // segment length, beats minus one
    typedef logic [SEG_LEN_W-1:0]  seg_len_t;
    typedef logic [NOC_ADDR_W-1:0] noc_addr_t;
    typedef logic [PAIR_NUM_W-1:0] pair_num_t;
    // completed segments with ping or pong in the low bit
    typedef logic [SEG_CNT_W-1:0]  seg_cnt_t;

endpackage
